// File: flist.f
+incdir+hw
+incdir+dv
hw/bytedecode_pkg.sv
hw/bytedecode_ctrl.sv
hw/bit_buffer.sv
hw/coeff_emitter.sv
hw/bytedecode_top.sv
dv/tb_bytedecode.sv

// File: Bender.yml
package:
  name: bytedecode

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/bytedecode_pkg.sv
      - hw/bytedecode_ctrl.sv
      - hw/bit_buffer.sv
      - hw/coeff_emitter.sv
      - hw/bytedecode_top.sv

  - target: test
    include_dirs:
      - hw
      - dv
    files:
      - dv/tb_bytedecode.sv

// File: dv/tb_bytedecode_cases.svh
/*
 * Byte decode frame cases
 * One row per frame, applied in order and back to back
 */
`ifndef TB_BYTEDECODE_CASES_SVH
`define TB_BYTEDECODE_CASES_SVH

// Columns are l, valid gap in percent, input words (4*l), output words (ceil(256/k))
typedef struct packed {
	logic [3:0]	l;
	logic [7:0]	gap_pct;
	logic [7:0]	in_words;
	logic [7:0]	out_words;
} case_row_t;

localparam int NUM_CASES = 12;

case_row_t case_table [NUM_CASES] = '{
	'{4'd1,  8'd0,  8'd4,  8'd4},
	'{4'd4,  8'd0,  8'd16, 8'd16},
	'{4'd5,  8'd0,  8'd20, 8'd22},
	'{4'd10, 8'd0,  8'd40, 8'd43},
	'{4'd11, 8'd0,  8'd44, 8'd52},
	'{4'd12, 8'd0,  8'd48, 8'd52},
	'{4'd12, 8'd40, 8'd48, 8'd52},
	'{4'd5,  8'd50, 8'd20, 8'd22},
	'{4'd11, 8'd30, 8'd44, 8'd52},
	'{4'd1,  8'd60, 8'd4,  8'd4},
	'{4'd10, 8'd25, 8'd40, 8'd43},
	'{4'd4,  8'd35, 8'd16, 8'd16}
};

`endif

// File: dv/tb_bytedecode.sv
/*
 * Byte decode testbench
 * Random frames per width, checked against a bit-level unpack model
 */
`timescale 1ns/10ps
`include "bytedecode_defs.svh"

module tb_bytedecode;

	`include "tb_bytedecode_cases.svh"

	localparam int XFER_TIMEOUT = 2000;
	localparam int DONE_TIMEOUT = 200;

	logic			i_clk;
	logic			i_rstn;
	logic [63:0]	i_ibytes;
	logic			i_ibytes_valid;
	logic			o_ibytes_ready;
	logic [3:0]		i_l;
	logic [63:0]	o_coeffs;
	logic			o_coeffs_valid;
	logic			o_done;

	int				seed = 11290;
	int				errors = 0;
	int				timeouts = 0;
	int				frames = 0;
	int				done_cnt = 0;
	bit				in_done = 1'b0;
	bit				prev_valid = 1'b0;
	bit				prev_done = 1'b0;
	logic [63:0]	acc_q [$];
	logic [63:0]	got_q [$];
	logic [63:0]	exp_q [$];

	bytedecode_top u_bytedecode_top (
		.i_clk			(i_clk),
		.i_rstn			(i_rstn),
		.i_ibytes		(i_ibytes),
		.i_ibytes_valid	(i_ibytes_valid),
		.o_ibytes_ready	(o_ibytes_ready),
		.i_l			(i_l),
		.o_coeffs		(o_coeffs),
		.o_coeffs_valid	(o_coeffs_valid),
		.o_done			(o_done)
	);

	initial i_clk = 1'b0;
	always #10 i_clk = ~i_clk;

	// ------------------------------
	// Stimulus helpers
	// ------------------------------
	function automatic logic [63:0] next_word();
		return {$random(seed), $random(seed)};
	endfunction

	// High unless this cycle falls into a gap
	function automatic logic pick_valid(input int gap_pct);
		return ($unsigned($random(seed)) % 100) >= gap_pct;
	endfunction

	function automatic logic stream_bit(input int pos);
		return acc_q[pos / 64][pos % 64];
	endfunction

	// LSB-first unpack, k coefficients per word, spare bits zero
	task automatic build_model(input int l);
		int k;
		int n_words;
		int j;
		int w;
		int s;
		int b;
		logic [63:0] word;
		k = 64 / l;
		n_words = (`BD_NUM_COEFFS + k - 1) / k;
		exp_q.delete();
		for (w = 0; w < n_words; w++) begin
			word = '0;
			for (s = 0; s < k; s++) begin
				j = w * k + s;
				if (j < `BD_NUM_COEFFS) begin
					for (b = 0; b < l; b++) begin
						word[s * l + b] = stream_bit(j * l + b);
					end
				end
			end
			exp_q.push_back(word);
		end
	endtask

	// ------------------------------
	// Driver
	// ------------------------------
	task automatic send_frame(input int l, input int n_in, input int gap_pct);
		int sent;
		int cycles;
		bit taken;
		sent = 0;
		cycles = 0;
		@(posedge i_clk);
		i_l <= 4'(l);
		i_ibytes <= next_word();
		i_ibytes_valid <= pick_valid(gap_pct);
		while (sent < n_in && cycles < XFER_TIMEOUT) begin
			@(negedge i_clk);
			taken = i_ibytes_valid && o_ibytes_ready;
			if (taken) begin
				acc_q.push_back(i_ibytes);
				sent++;
			end
			@(posedge i_clk);
			cycles++;
			if (sent == n_in) begin
				i_ibytes_valid <= 1'b0;
				in_done = 1'b1;
			end else if (taken || !i_ibytes_valid) begin
				if (taken) begin
					i_ibytes <= next_word();
				end
				i_ibytes_valid <= pick_valid(gap_pct);
			end
		end
		if (sent < n_in) begin
			$display("Timeout: input word %0d of %0d was never accepted", sent, n_in);
			timeouts++;
			i_ibytes_valid <= 1'b0;
		end
	endtask

	task automatic wait_done(input int done_before);
		int cycles;
		cycles = 0;
		while (done_cnt == done_before && cycles < DONE_TIMEOUT) begin
			@(posedge i_clk);
			cycles++;
		end
		if (done_cnt == done_before) begin
			$display("Timeout: o_done never arrived after the last input word");
			timeouts++;
		end
	endtask

	// ------------------------------
	// Output monitor
	// ------------------------------
	always @(negedge i_clk) begin
		if (i_rstn) begin
			if (o_coeffs_valid) begin
				got_q.push_back(o_coeffs);
			end
			if (o_done && !prev_valid) begin
				$display("o_done rose without an o_coeffs_valid beat in the cycle before");
				errors++;
			end
			if (o_done && prev_done) begin
				$display("o_done stayed high for more than one cycle");
				errors++;
			end
			if (o_done) begin
				done_cnt++;
			end
			if (in_done && !o_done && o_ibytes_ready) begin
				$display("o_ibytes_ready rose after the last input word, before o_done");
				errors++;
			end
			prev_valid = o_coeffs_valid;
			prev_done = o_done;
		end
	end

	// ------------------------------
	// Frame checks
	// ------------------------------
	task automatic check_frame(input case_row_t row);
		int n;
		int i;
		build_model(row.l);
		if (got_q.size() != row.out_words) begin
			$display("FAILED: o_coeffs_valid beats expected %h got %h", row.out_words,
				got_q.size());
			errors++;
		end
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		for (i = 0; i < n; i++) begin
			if (got_q[i] !== exp_q[i]) begin
				$display("FAILED: o_coeffs beat %0d l=%0d expected %h got %h", i, row.l,
					exp_q[i], got_q[i]);
				errors++;
			end
		end
	endtask

	initial begin
		int c;
		int done_before;
		i_rstn <= 1'b0;
		i_ibytes <= '0;
		i_ibytes_valid <= 1'b0;
		i_l <= 4'd1;
		repeat (16) @(posedge i_clk);
		i_rstn <= 1'b1;

		@(negedge i_clk);
		if (o_coeffs_valid !== 1'b0 || o_done !== 1'b0 || o_ibytes_ready !== 1'b1) begin
			$display("FAILED: reset state valid/done/ready expected %h got %h", 3'b001,
				{o_coeffs_valid, o_done, o_ibytes_ready});
			errors++;
		end

		c = 0;
		while (c < NUM_CASES && timeouts == 0) begin
			acc_q.delete();
			got_q.delete();
			done_before = done_cnt;
			send_frame(case_table[c].l, case_table[c].in_words, case_table[c].gap_pct);
			if (timeouts == 0) begin
				wait_done(done_before);
			end
			in_done = 1'b0;
			if (timeouts == 0) begin
				check_frame(case_table[c]);
				frames++;
			end
			c++;
		end

		$display("Frames: %0d, errors: %0d, timeouts: %0d", frames, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: hw/bytedecode_top.sv
/*
 * Byte decode top
 * Unpacks a 64-bit byte stream into 256 coefficients of width l
 */
`timescale 1ns/10ps
`include "bytedecode_defs.svh"

module bytedecode_top (
	input  logic					i_clk,
	input  logic					i_rstn,
	input  logic [`BD_WORD_W-1:0]	i_ibytes,
	input  logic					i_ibytes_valid,
	output logic					o_ibytes_ready,
	input  logic [3:0]				i_l,
	output logic [`BD_WORD_W-1:0]	o_coeffs,
	output logic					o_coeffs_valid,
	output logic					o_done
);

	logic							load;
	logic [`BD_FILL_W-1:0]			take;
	logic [`BD_FILL_W-1:0]			fill;
	logic							clear;
	logic							emit;
	logic							last;
	logic [`BD_WORD_W-1:0]			window;
	bytedecode_pkg::coeff_width_e	width;

	bytedecode_ctrl u_ctrl (
		.i_clk			(i_clk),
		.i_rstn			(i_rstn),
		.i_ibytes_valid	(i_ibytes_valid),
		.i_l			(i_l),
		.i_fill			(fill),
		.i_last			(last),
		.o_ibytes_ready	(o_ibytes_ready),
		.o_load			(load),
		.o_take			(take),
		.o_emit			(emit),
		.o_width		(width),
		.o_clear		(clear),
		.o_done			(o_done)
	);

	bit_buffer u_buf (
		.i_clk			(i_clk),
		.i_rstn			(i_rstn),
		.i_load			(load),
		.i_ibytes		(i_ibytes),
		.i_take			(take),
		.i_clear		(clear),
		.o_window		(window),
		.o_fill			(fill)
	);

	coeff_emitter u_emit (
		.i_clk			(i_clk),
		.i_rstn			(i_rstn),
		.i_emit			(emit),
		.i_width		(width),
		.i_window		(window),
		.o_coeffs		(o_coeffs),
		.o_coeffs_valid	(o_coeffs_valid),
		.o_last			(last)
	);

endmodule

// File: hw/coeff_emitter.sv
/*
 * Coefficient emitter
 * Masks the reservoir window into an output word and tracks the frame's last word
 */
`timescale 1ns/10ps
`include "bytedecode_defs.svh"

module coeff_emitter (
	input  logic							i_clk,
	input  logic							i_rstn,
	input  logic							i_emit,
	input  bytedecode_pkg::coeff_width_e	i_width,
	input  logic [`BD_WORD_W-1:0]			i_window,
	output logic [`BD_WORD_W-1:0]			o_coeffs,
	output logic							o_coeffs_valid,
	output logic							o_last
);

	logic [`BD_OUTCNT_W-1:0]	out_cnt_q;
	logic [`BD_OUTCNT_W-1:0]	last_idx;
	logic [6:0]					word_bits;
	logic [`BD_WORD_W-1:0]		mask;

	// ------------------------------
	// Word size and mask
	// ------------------------------
	assign last_idx = bytedecode_pkg::out_words(i_width) - 1'b1;
	assign o_last   = (out_cnt_q == last_idx);

	always_comb begin
		if (o_last) begin
			word_bits = bytedecode_pkg::last_bits(i_width);
		end else begin
			word_bits = 7'(bytedecode_pkg::coeffs_per_word(i_width) * i_width);
		end
	end

	// Shift by 64 yields zero, so a full word keeps every bit
	assign mask = ~({`BD_WORD_W{1'b1}} << word_bits);

	// ------------------------------
	// Output word and count
	// ------------------------------
	always_ff @(posedge i_clk) begin
		if (i_emit) begin
			o_coeffs <= i_window & mask;
		end
	end

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			o_coeffs_valid <= 1'b0;
			out_cnt_q      <= '0;
		end else begin
			o_coeffs_valid <= i_emit;
			if (i_emit) begin
				if (o_last) begin
					out_cnt_q <= '0;
				end else begin
					out_cnt_q <= out_cnt_q + 1'b1;
				end
			end
		end
	end

	// ------------------------------
	// Checks
	// ------------------------------
	// Done cycle and the earliest restart leave two quiet cycles after the last beat
	a_quiet_after_last: assert property (
		@(posedge i_clk) disable iff (!i_rstn)
		(i_emit && o_last) |-> ##2 !o_coeffs_valid [*2]
	);

endmodule

// File: hw/bit_buffer.sv
/*
 * Bit reservoir
 * Appends input words above the fill level, drops consumed bits from the bottom
 */
`timescale 1ns/10ps
`include "bytedecode_defs.svh"

module bit_buffer (
	input  logic					i_clk,
	input  logic					i_rstn,
	input  logic					i_load,
	input  logic [`BD_WORD_W-1:0]	i_ibytes,
	input  logic [`BD_FILL_W-1:0]	i_take,
	input  logic					i_clear,
	output logic [`BD_WORD_W-1:0]	o_window,
	output logic [`BD_FILL_W-1:0]	o_fill
);

	logic [`BD_BUF_W-1:0]	buf_q;
	logic [`BD_FILL_W-1:0]	fill_q;
	logic [`BD_BUF_W-1:0]	kept;
	logic [`BD_FILL_W-1:0]	kept_fill;
	logic [`BD_BUF_W-1:0]	incoming;

	// ------------------------------
	// Consume, then append
	// ------------------------------
	assign kept      = buf_q >> i_take;
	assign kept_fill = fill_q - i_take;

	// New word lands right above what is left
	assign incoming = {{(`BD_BUF_W-`BD_WORD_W){1'b0}}, i_ibytes} << kept_fill;

	// Bits above the fill level stay zero, so OR is enough to append
	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			buf_q  <= '0;
			fill_q <= '0;
		end else if (i_clear) begin
			buf_q  <= '0;
			fill_q <= '0;
		end else if (i_load) begin
			buf_q  <= kept | incoming;
			fill_q <= kept_fill + `BD_FILL_W'(`BD_WORD_W);
		end else begin
			buf_q  <= kept;
			fill_q <= kept_fill;
		end
	end

	assign o_window = buf_q[`BD_WORD_W-1:0];
	assign o_fill   = fill_q;

	// ------------------------------
	// Checks
	// ------------------------------
	a_fill_max: assert property (
		@(posedge i_clk) disable iff (!i_rstn)
		fill_q <= `BD_FILL_W'(`BD_BUF_W)
	);

	// Control may only consume bits already held
	a_take_le_fill: assert property (
		@(posedge i_clk) disable iff (!i_rstn)
		i_take <= fill_q
	);

endmodule

// File: hw/bytedecode_ctrl.sv
/*
 * Byte decode control
 * Frame FSM, input acceptance and per-cycle consume amount
 */
`timescale 1ns/10ps
`include "bytedecode_defs.svh"

module bytedecode_ctrl (
	input  logic							i_clk,
	input  logic							i_rstn,
	input  logic							i_ibytes_valid,
	input  logic [3:0]						i_l,
	input  logic [`BD_FILL_W-1:0]			i_fill,
	input  logic							i_last,
	output logic							o_ibytes_ready,
	output logic							o_load,
	output logic [`BD_FILL_W-1:0]			o_take,
	output logic							o_emit,
	output bytedecode_pkg::coeff_width_e	o_width,
	output logic							o_clear,
	output logic							o_done
);

	bytedecode_pkg::ctrl_state_e	state_q;
	bytedecode_pkg::coeff_width_e	width_q;
	logic [`BD_OUTCNT_W-1:0]		in_cnt_q;
	logic [`BD_OUTCNT_W-1:0]		in_words;
	logic [6:0]						full_bits;
	logic [`BD_FILL_W-1:0]			word_bits;

	// ------------------------------
	// Per-width sizes
	// ------------------------------
	// 4*l input words per frame
	assign in_words  = {width_q, 2'b00};
	assign full_bits = 7'(bytedecode_pkg::coeffs_per_word(width_q) * width_q);

	always_comb begin
		if (i_last) begin
			word_bits = {1'b0, bytedecode_pkg::last_bits(width_q)};
		end else begin
			word_bits = {1'b0, full_bits};
		end
	end

	// ------------------------------
	// Acceptance and emission
	// ------------------------------
	always_comb begin
		o_ibytes_ready = 1'b0;
		o_emit         = 1'b0;
		case (state_q)
			bytedecode_pkg::S_IDLE: begin
				o_ibytes_ready = 1'b1;
			end
			bytedecode_pkg::S_RUN: begin
				o_ibytes_ready = (i_fill <= `BD_FILL_W'(`BD_WORD_W)) && (in_cnt_q < in_words);
				o_emit         = (i_fill >= word_bits);
			end
			default: begin
				o_ibytes_ready = 1'b0;
			end
		endcase
	end

	assign o_load  = i_ibytes_valid & o_ibytes_ready;
	assign o_take  = o_emit ? word_bits : '0;
	assign o_width = width_q;
	assign o_clear = (state_q == bytedecode_pkg::S_DONE);

	// ------------------------------
	// Frame FSM
	// ------------------------------
	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			state_q  <= bytedecode_pkg::S_IDLE;
			width_q  <= bytedecode_pkg::W1;
			in_cnt_q <= '0;
			o_done   <= 1'b0;
		end else begin
			// Done trails the final valid beat by one cycle
			o_done <= (state_q == bytedecode_pkg::S_DONE);
			case (state_q)
				bytedecode_pkg::S_IDLE: begin
					if (o_load) begin
						state_q  <= bytedecode_pkg::S_RUN;
						width_q  <= bytedecode_pkg::coeff_width_e'(i_l);
						in_cnt_q <= `BD_OUTCNT_W'(1);
					end
				end
				bytedecode_pkg::S_RUN: begin
					if (o_load) begin
						in_cnt_q <= in_cnt_q + 1'b1;
					end
					if (o_emit && i_last) begin
						state_q <= bytedecode_pkg::S_DONE;
					end
				end
				default: begin
					state_q <= bytedecode_pkg::S_IDLE;
				end
			endcase
		end
	end

	// ------------------------------
	// Checks
	// ------------------------------
	// Width taken at the first transfer must be one of the legal l values
	a_legal_width: assert property (
		@(posedge i_clk) disable iff (!i_rstn)
		(state_q == bytedecode_pkg::S_IDLE && o_load) |=>
			width_q inside {bytedecode_pkg::W1, bytedecode_pkg::W4, bytedecode_pkg::W5,
			                bytedecode_pkg::W10, bytedecode_pkg::W11, bytedecode_pkg::W12}
	);

	// Frame closes only with every input word taken and every bit consumed
	a_done_drained: assert property (
		@(posedge i_clk) disable iff (!i_rstn)
		(state_q == bytedecode_pkg::S_DONE) |-> (in_cnt_q == in_words) && (i_fill == '0)
	);

endmodule

// File: hw/bytedecode_pkg.sv
/*
 * Byte decode types
 * Legal widths, FSM states and per-width frame lookups
 */
`include "bytedecode_defs.svh"

package bytedecode_pkg;

	typedef enum logic [3:0] {
		W1  = 4'd1,
		W4  = 4'd4,
		W5  = 4'd5,
		W10 = 4'd10,
		W11 = 4'd11,
		W12 = 4'd12
	} coeff_width_e;

	typedef enum logic [1:0] {
		S_IDLE = 2'd0,
		S_RUN  = 2'd1,
		S_DONE = 2'd2
	} ctrl_state_e;

	// k = floor(64/l)
	function automatic logic [6:0] coeffs_per_word(coeff_width_e w);
		case (w)
			W1:      return 7'd64;
			W4:      return 7'd16;
			W5:      return 7'd12;
			W10:     return 7'd6;
			default: return 7'd5;
		endcase
	endfunction

	function automatic logic [5:0] out_words(coeff_width_e w);
		case (w)
			W1:      return 6'd4;
			W4:      return 6'd16;
			W5:      return 6'd22;
			W10:     return 6'd43;
			default: return 6'd52;
		endcase
	endfunction

	// Coefficients left over for the final word, times l
	function automatic logic [6:0] last_bits(coeff_width_e w);
		int unsigned left;
		left = `BD_NUM_COEFFS - (out_words(w) - 1) * coeffs_per_word(w);
		return 7'(left * w);
	endfunction

endpackage

// File: hw/bytedecode_defs.svh
/*
 * Byte decode sizing
 * Word, reservoir and counter widths for the coefficient unpacker
 */
`ifndef BYTEDECODE_DEFS_SVH
`define BYTEDECODE_DEFS_SVH

// Input and output word
`define BD_WORD_W		64

// Bit reservoir, two words deep
`define BD_BUF_W		128

// Fill and consume counts, 0 to 128
`define BD_FILL_W		8

`define BD_NUM_COEFFS	256

// Output words per frame, up to 52
`define BD_OUTCNT_W		6

`endif
